//--- logic/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////////////////////////
    // widths

    localparam int ADDR_W   = 32;
    localparam int LINE_W   = 128;                 // 16 bytes per line
    localparam int OFFSET_W = 4;                   // byte offset in a line
    localparam int FIP_W    = ADDR_W - OFFSET_W;   // line address
    localparam int INDEX_W  = 4;                   // sized for 16 lines per bank
    localparam int TAG_W    = ADDR_W - INDEX_W - 1 - OFFSET_W;

    //////////////////////////////////////////////////
    // types

    typedef logic [FIP_W-1:0]  fip_t;
    typedef logic [LINE_W-1:0] line_t;

    // field view of a fetch address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;     // 31:9
        logic [INDEX_W-1:0]  index;   // 8:5
        logic                bank;    // bit 4, odd bank when set
        logic [OFFSET_W-1:0] offset;  // 3:0
    } fetch_fields_t;

    // same word seen flat or split into fields
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        fetch_fields_t     f;
    } fetch_addr_u;

endpackage

//--- logic/fetch_lookup_if.sv
interface fetch_lookup_if;

    // request side
    logic             req_valid;
    fetch_pkg::fip_t  fip;

    // registered answer from the bank
    logic             hit;
    fetch_pkg::line_t line;
    logic             miss;

    // one cycle pulse when the line is taken
    logic             loaded;

    modport producer (
        output req_valid,
        output fip,
        input  loaded
    );

    modport bank (
        input  req_valid,
        input  fip,
        output hit,
        output line,
        output miss
    );

    modport consumer (
        input  fip,
        input  hit,
        input  line,
        input  miss,
        output loaded
    );

endinterface

//--- logic/fetch_addr_gen.sv
module fetch_addr_gen (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  fetch_pkg::fetch_addr_u init_addr_i,
    input  logic                   is_init_i,
    input  logic                   is_resteer_i,
    input  logic                   is_br_i,
    input  fetch_pkg::fip_t        wb_fip_even_i,
    input  fetch_pkg::fip_t        wb_fip_odd_i,
    input  fetch_pkg::fip_t        bp_fip_even_i,
    input  fetch_pkg::fip_t        bp_fip_odd_i,
    fetch_lookup_if.producer       even_if,
    fetch_lookup_if.producer       odd_if
);

    localparam fetch_pkg::fip_t ONE_LINE  = fetch_pkg::fip_t'(1);
    localparam fetch_pkg::fip_t TWO_LINES = fetch_pkg::fip_t'(2);

    fetch_pkg::fip_t fip_even_q;
    fetch_pkg::fip_t fip_odd_q;
    logic            req_valid_q;

    fetch_pkg::fip_t init_line;
    fetch_pkg::fip_t init_next;
    fetch_pkg::fip_t init_fip_even;
    fetch_pkg::fip_t init_fip_odd;
    fetch_pkg::fip_t cf_fip_even;
    fetch_pkg::fip_t cf_fip_odd;
    logic            is_cf;

    //////////////////////////////////////////////////
    // init line pair

    assign init_line = init_addr_i.flat[fetch_pkg::ADDR_W-1:fetch_pkg::OFFSET_W];
    assign init_next = init_line + ONE_LINE;

    // the init line goes to its own bank, the other bank gets the next line
    assign init_fip_even = init_addr_i.flat[fetch_pkg::OFFSET_W] ? init_next : init_line;
    assign init_fip_odd  = init_addr_i.flat[fetch_pkg::OFFSET_W] ? init_line : init_next;

    //////////////////////////////////////////////////
    // control flow priority, init > resteer > branch

    assign is_cf = is_init_i | is_resteer_i | is_br_i;

    always_comb begin
        cf_fip_even = bp_fip_even_i;
        cf_fip_odd  = bp_fip_odd_i;
        if (is_init_i) begin
            cf_fip_even = init_fip_even;
            cf_fip_odd  = init_fip_odd;
        end else if (is_resteer_i) begin
            cf_fip_even = wb_fip_even_i;
            cf_fip_odd  = wb_fip_odd_i;
        end
    end

    //////////////////////////////////////////////////
    // FIP registers

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fip_even_q  <= '0;
            fip_odd_q   <= '0;
            req_valid_q <= 1'b0;
        end else begin
            if (is_cf) begin
                fip_even_q <= cf_fip_even;  // preempts any advance
                fip_odd_q  <= cf_fip_odd;
            end else begin
                if (even_if.loaded) begin
                    fip_even_q <= fip_even_q + TWO_LINES;
                end
                if (odd_if.loaded) begin
                    fip_odd_q <= fip_odd_q + TWO_LINES;
                end
            end
            if (is_init_i) begin
                req_valid_q <= 1'b1;  // stays up from the first init on
            end
        end
    end

    assign even_if.req_valid = req_valid_q;
    assign even_if.fip       = fip_even_q;
    assign odd_if.req_valid  = req_valid_q;
    assign odd_if.fip        = fip_odd_q;

    // line stage only takes lines that were requested
    a_loaded_needs_req : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (even_if.loaded || odd_if.loaded) |-> req_valid_q
    ) else $error("loaded pulse without an active request");

endmodule

//--- logic/icache_bank.sv
module icache_bank #(
    parameter int LINES_PER_BANK = 16,
    parameter bit ODD_BANK       = 1'b0
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   refill_valid_i,
    input  fetch_pkg::fetch_addr_u refill_addr_i,
    input  fetch_pkg::line_t       refill_line_i,
    fetch_lookup_if.bank           lookup_if,
    output logic                   miss_o,
    output fetch_pkg::fip_t        miss_addr_o
);

    localparam int IDX_W = $clog2(LINES_PER_BANK);
    // tag plus the full index field, so smaller banks still compare right
    localparam int KEY_W = fetch_pkg::TAG_W + fetch_pkg::INDEX_W;

    fetch_pkg::line_t          data_mem [LINES_PER_BANK];
    logic [KEY_W-1:0]          key_mem  [LINES_PER_BANK];
    logic [LINES_PER_BANK-1:0] valid_q;

    fetch_pkg::fetch_addr_u lookup_addr;
    logic [IDX_W-1:0]       rd_idx;
    logic [IDX_W-1:0]       wr_idx;
    logic [KEY_W-1:0]       rd_key;
    logic [KEY_W-1:0]       wr_key;
    logic                   tag_match;

    logic             hit_q;
    logic             miss_q;
    fetch_pkg::fip_t  fip_q;
    fetch_pkg::line_t line_q;
    logic             same_fip;

    //////////////////////////////////////////////////
    // address decode

    assign lookup_addr = {lookup_if.fip, {fetch_pkg::OFFSET_W{1'b0}}};

    assign rd_idx = lookup_addr.f.index[IDX_W-1:0];
    assign rd_key = {lookup_addr.f.tag, lookup_addr.f.index};
    assign wr_idx = refill_addr_i.f.index[IDX_W-1:0];
    assign wr_key = {refill_addr_i.f.tag, refill_addr_i.f.index};

    assign tag_match = valid_q[rd_idx] && (key_mem[rd_idx] == rd_key);

    //////////////////////////////////////////////////
    // lookup, answered one cycle later

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hit_q  <= 1'b0;
            miss_q <= 1'b0;
            fip_q  <= '0;
        end else begin
            hit_q  <= lookup_if.req_valid & tag_match;
            miss_q <= lookup_if.req_valid & ~tag_match;
            fip_q  <= lookup_if.fip;
        end
    end

    always_ff @(posedge clk) begin
        line_q <= data_mem[rd_idx];
    end

    // stale answer once the FIP has moved on
    assign same_fip = (fip_q == lookup_if.fip);

    assign lookup_if.hit  = hit_q & same_fip;
    assign lookup_if.miss = miss_q & same_fip;
    assign lookup_if.line = line_q;

    assign miss_o      = lookup_if.miss;
    assign miss_addr_o = fip_q;  // line address that missed

    //////////////////////////////////////////////////
    // refill

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (refill_valid_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_valid_i) begin
            data_mem[wr_idx] <= refill_line_i;
            key_mem[wr_idx]  <= wr_key;
        end
    end

    // top level steers refills by refill_odd_i, the address has to agree
    a_refill_bank : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        refill_valid_i |-> (refill_addr_i.f.bank == ODD_BANK)
    ) else $error("refill routed to the wrong bank");

endmodule

//--- logic/fetch_line_stage.sv
module fetch_line_stage (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             stall_i,
    input  logic             flush_i,
    fetch_lookup_if.consumer even_if,
    fetch_lookup_if.consumer odd_if,
    output fetch_pkg::line_t line_even_o,
    output fetch_pkg::line_t line_odd_o,
    output logic             line_valid_o,
    output logic [1:0]       fip_even_lsb_o,
    output logic [1:0]       fip_odd_lsb_o
);

    fetch_pkg::line_t line_even_q;
    fetch_pkg::line_t line_odd_q;
    logic [1:0]       fip_even_lsb_q;
    logic [1:0]       fip_odd_lsb_q;
    logic             line_valid_q;
    logic             capture;

    //////////////////////////////////////////////////
    // capture decision

    // both halves of the pair or nothing
    assign capture = even_if.hit & odd_if.hit & ~stall_i & ~flush_i;

    assign even_if.loaded = capture;
    assign odd_if.loaded  = capture;

    //////////////////////////////////////////////////
    // output registers

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            line_valid_q <= 1'b0;
        end else if (!stall_i) begin
            line_valid_q <= capture;  // held while stalled
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            line_even_q    <= even_if.line;
            line_odd_q     <= odd_if.line;
            // address bits 5:4
            fip_even_lsb_q <= even_if.fip[1:0];
            fip_odd_lsb_q  <= odd_if.fip[1:0];
        end
    end

    assign line_even_o    = line_even_q;
    assign line_odd_o     = line_odd_q;
    assign line_valid_o   = line_valid_q;
    assign fip_even_lsb_o = fip_even_lsb_q;
    assign fip_odd_lsb_o  = fip_odd_lsb_q;

    // even lines have address bit 4 clear, odd lines have it set
    a_loaded_bank_bit : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        capture |-> (!even_if.fip[0] && odd_if.fip[0])
    ) else $error("pair taken with a line from the wrong bank");

endmodule

//--- logic/fetch_top.sv
module fetch_top #(
    parameter int LINES_PER_BANK = 16  // power of two
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    // control flow
    input  logic [fetch_pkg::ADDR_W-1:0]  init_addr_i,
    input  logic                          is_init_i,
    input  logic                          is_resteer_i,
    input  logic                          is_br_i,
    input  fetch_pkg::fip_t               wb_fip_even_i,
    input  fetch_pkg::fip_t               wb_fip_odd_i,
    input  fetch_pkg::fip_t               bp_fip_even_i,
    input  fetch_pkg::fip_t               bp_fip_odd_i,
    // decoder side
    input  logic                          stall_i,
    output fetch_pkg::line_t              line_even_o,
    output fetch_pkg::line_t              line_odd_o,
    output logic                          line_valid_o,
    output logic [1:0]                    fip_even_lsb_o,
    output logic [1:0]                    fip_odd_lsb_o,
    // miss report and refill
    output logic                          miss_even_o,
    output logic                          miss_odd_o,
    output fetch_pkg::fip_t               miss_addr_even_o,
    output fetch_pkg::fip_t               miss_addr_odd_o,
    input  logic                          refill_valid_i,
    input  logic                          refill_odd_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  refill_addr_i,
    input  fetch_pkg::line_t              refill_line_i
);

    fetch_pkg::fetch_addr_u init_addr;
    fetch_pkg::fetch_addr_u refill_addr;
    logic                   flush;

    assign init_addr.flat   = init_addr_i;
    assign refill_addr.flat = refill_addr_i;
    assign flush = is_init_i | is_resteer_i | is_br_i;

    fetch_lookup_if even_if ();
    fetch_lookup_if odd_if ();

    fetch_addr_gen u_addr_gen (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .init_addr_i   (init_addr),
        .is_init_i     (is_init_i),
        .is_resteer_i  (is_resteer_i),
        .is_br_i       (is_br_i),
        .wb_fip_even_i (wb_fip_even_i),
        .wb_fip_odd_i  (wb_fip_odd_i),
        .bp_fip_even_i (bp_fip_even_i),
        .bp_fip_odd_i  (bp_fip_odd_i),
        .even_if       (even_if),
        .odd_if        (odd_if)
    );

    icache_bank #(.LINES_PER_BANK(LINES_PER_BANK), .ODD_BANK(1'b0)) u_bank_even (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .refill_valid_i (refill_valid_i & ~refill_odd_i),
        .refill_addr_i  (refill_addr),
        .refill_line_i  (refill_line_i),
        .lookup_if      (even_if),
        .miss_o         (miss_even_o),
        .miss_addr_o    (miss_addr_even_o)
    );

    icache_bank #(.LINES_PER_BANK(LINES_PER_BANK), .ODD_BANK(1'b1)) u_bank_odd (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .refill_valid_i (refill_valid_i & refill_odd_i),
        .refill_addr_i  (refill_addr),
        .refill_line_i  (refill_line_i),
        .lookup_if      (odd_if),
        .miss_o         (miss_odd_o),
        .miss_addr_o    (miss_addr_odd_o)
    );

    fetch_line_stage u_line_stage (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .stall_i        (stall_i),
        .flush_i        (flush),
        .even_if        (even_if),
        .odd_if         (odd_if),
        .line_even_o    (line_even_o),
        .line_odd_o     (line_odd_o),
        .line_valid_o   (line_valid_o),
        .fip_even_lsb_o (fip_even_lsb_o),
        .fip_odd_lsb_o  (fip_odd_lsb_o)
    );

endmodule

//--- include/fetch_tb_model.svh
`ifndef FETCH_TB_MODEL_SVH
`define FETCH_TB_MODEL_SVH

// fill pattern, different for every line and every word
function automatic fetch_pkg::line_t line_data(input fetch_pkg::fip_t addr);
    fetch_pkg::line_t line;
    line = '0;
    for (int w = 0; w < 4; w++) begin
        line[w*32 +: 32] = {addr, 4'(w)} ^ (32'h9e37_79b9 * 32'(w + 1));
    end
    return line;
endfunction

// even and odd line addresses that an init starts from
function automatic void init_pair(input  logic [31:0]     addr,
                                  output fetch_pkg::fip_t even,
                                  output fetch_pkg::fip_t odd);
    fetch_pkg::fip_t this_line;
    this_line = addr[31:4];
    if (addr[4]) begin
        odd  = this_line;
        even = this_line + fetch_pkg::fip_t'(1);
    end else begin
        even = this_line;
        odd  = this_line + fetch_pkg::fip_t'(1);
    end
endfunction

// next pair under control flow, returns 0 when none is present
function automatic bit select_cf(input  bit              init,
                                 input  bit              resteer,
                                 input  bit              br,
                                 input  logic [31:0]     init_addr,
                                 input  fetch_pkg::fip_t wb_even,
                                 input  fetch_pkg::fip_t wb_odd,
                                 input  fetch_pkg::fip_t bp_even,
                                 input  fetch_pkg::fip_t bp_odd,
                                 inout  fetch_pkg::fip_t even,
                                 inout  fetch_pkg::fip_t odd);
    if (init) begin
        init_pair(init_addr, even, odd);
    end else if (resteer) begin
        even = wb_even;
        odd  = wb_odd;
    end else if (br) begin
        even = bp_even;
        odd  = bp_odd;
    end
    return init | resteer | br;
endfunction

// sequential step after a delivered pair
function automatic void advance_pair(inout fetch_pkg::fip_t even, inout fetch_pkg::fip_t odd);
    even = even + fetch_pkg::fip_t'(2);
    odd  = odd + fetch_pkg::fip_t'(2);
endfunction

`endif

//--- verification/fetch_tb.sv
module fetch_tb;

    localparam logic [31:0] SEED        = 32'h25bf_9579;
    localparam int          PAIR_LIMIT  = 40;    // cycles allowed per delivered pair
    localparam int          TOTAL_PAIRS = 44;
    localparam int          WATCHDOG_CYCLES = 8 + TOTAL_PAIRS * PAIR_LIMIT + 200;

    logic             clk = 1'b0;
    logic             rst_n_i;
    logic [31:0]      init_addr_i;
    logic             is_init_i;
    logic             is_resteer_i;
    logic             is_br_i;
    fetch_pkg::fip_t  wb_fip_even_i;
    fetch_pkg::fip_t  wb_fip_odd_i;
    fetch_pkg::fip_t  bp_fip_even_i;
    fetch_pkg::fip_t  bp_fip_odd_i;
    logic             stall_i;
    fetch_pkg::line_t line_even_o;
    fetch_pkg::line_t line_odd_o;
    logic             line_valid_o;
    logic [1:0]       fip_even_lsb_o;
    logic [1:0]       fip_odd_lsb_o;
    logic             miss_even_o;
    logic             miss_odd_o;
    fetch_pkg::fip_t  miss_addr_even_o;
    fetch_pkg::fip_t  miss_addr_odd_o;
    logic             refill_valid_i;
    logic             refill_odd_i;
    logic [31:0]      refill_addr_i;
    fetch_pkg::line_t refill_line_i;

    // model state, owned by the compare process
    fetch_pkg::fip_t  exp_even   = '0;
    fetch_pkg::fip_t  exp_odd    = '0;
    logic             last_valid = 1'b0;
    fetch_pkg::line_t last_even;
    fetch_pkg::line_t last_odd;
    int               captures   = 0;
    int               miss_count = 0;
    int               cmp_errors = 0;

    // stall and control flow as seen at the last rising edge
    logic             stall_q   = 1'b0;
    logic             cf_q      = 1'b0;
    fetch_pkg::fip_t  cf_even_q = '0;
    fetch_pkg::fip_t  cf_odd_q  = '0;

    int               stim_errors = 0;
    int               test_num    = 0;
    int               test_base   = 0;
    logic [31:0]      stim_state;
    logic [31:0]      resp_state;
    logic             refill_en = 1'b0;

    always #4 clk = ~clk;

    fetch_top dut (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .init_addr_i      (init_addr_i),
        .is_init_i        (is_init_i),
        .is_resteer_i     (is_resteer_i),
        .is_br_i          (is_br_i),
        .wb_fip_even_i    (wb_fip_even_i),
        .wb_fip_odd_i     (wb_fip_odd_i),
        .bp_fip_even_i    (bp_fip_even_i),
        .bp_fip_odd_i     (bp_fip_odd_i),
        .stall_i          (stall_i),
        .line_even_o      (line_even_o),
        .line_odd_o       (line_odd_o),
        .line_valid_o     (line_valid_o),
        .fip_even_lsb_o   (fip_even_lsb_o),
        .fip_odd_lsb_o    (fip_odd_lsb_o),
        .miss_even_o      (miss_even_o),
        .miss_odd_o       (miss_odd_o),
        .miss_addr_even_o (miss_addr_even_o),
        .miss_addr_odd_o  (miss_addr_odd_o),
        .refill_valid_i   (refill_valid_i),
        .refill_odd_i     (refill_odd_i),
        .refill_addr_i    (refill_addr_i),
        .refill_line_i    (refill_line_i)
    );

    `include "fetch_tb_model.svh"

    // linear congruential generator
    function automatic logic [31:0] next_rand(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    // one compare, 1 on mismatch
    function automatic int check_val(input string name, input logic [127:0] got,
                                     input logic [127:0] exp);
        int bad;
        bad = 0;
        assert (got === exp) else begin
            $display("[ERROR] %s = %h, expected %h", name, got, exp);
            bad = 1;
        end
        return bad;
    endfunction

    //////////////////////////////////////////////////
    // model and compare

    always @(posedge clk) begin : sample_inputs
        fetch_pkg::fip_t nxt_even;
        fetch_pkg::fip_t nxt_odd;
        bit              cf_seen;
        nxt_even = exp_even;
        nxt_odd  = exp_odd;
        cf_seen  = select_cf(is_init_i, is_resteer_i, is_br_i, init_addr_i,
                             wb_fip_even_i, wb_fip_odd_i, bp_fip_even_i, bp_fip_odd_i,
                             nxt_even, nxt_odd);
        stall_q   <= stall_i;
        cf_q      <= cf_seen;
        cf_even_q <= nxt_even;
        cf_odd_q  <= nxt_odd;
    end

    always @(negedge clk) begin
        if (rst_n_i) begin
            if (miss_even_o || miss_odd_o) begin
                miss_count++;
            end
            if (line_valid_o && !stall_q) begin
                // fresh pair taken at the last rising edge
                cmp_errors += check_val("line_even_o", line_even_o, line_data(exp_even));
                cmp_errors += check_val("line_odd_o", line_odd_o, line_data(exp_odd));
                cmp_errors += check_val("fip_even_lsb_o", 128'(fip_even_lsb_o),
                                        128'(exp_even[1:0]));
                cmp_errors += check_val("fip_odd_lsb_o", 128'(fip_odd_lsb_o),
                                        128'(exp_odd[1:0]));
                captures++;
                advance_pair(exp_even, exp_odd);
            end else if (stall_q) begin
                cmp_errors += check_val("line_valid_o", 128'(line_valid_o), 128'(last_valid));
                if (last_valid) begin   // held pair
                    cmp_errors += check_val("line_even_o", line_even_o, last_even);
                    cmp_errors += check_val("line_odd_o", line_odd_o, last_odd);
                end
            end
            if (cf_q) begin
                exp_even = cf_even_q;
                exp_odd  = cf_odd_q;
            end
            last_valid = line_valid_o;
            last_even  = line_even_o;
            last_odd   = line_odd_o;
        end
    end

    //////////////////////////////////////////////////
    // refill responder

    initial begin : refill_responder
        logic [31:0]     r;
        fetch_pkg::fip_t addr;
        logic            odd;
        resp_state     = ~SEED;
        refill_valid_i = 1'b0;
        refill_odd_i   = 1'b0;
        refill_addr_i  = '0;
        refill_line_i  = '0;
        forever begin
            @(negedge clk);
            if (refill_en && (miss_even_o || miss_odd_o)) begin
                odd  = !miss_even_o;   // even bank first
                addr = odd ? miss_addr_odd_o : miss_addr_even_o;
                r    = next_rand(resp_state);
                repeat (r[17:16]) @(negedge clk);
                refill_valid_i = 1'b1;
                refill_odd_i   = odd;
                refill_addr_i  = {addr, 4'h0};
                refill_line_i  = line_data(addr);
                @(negedge clk);
                refill_valid_i = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus tasks

    task automatic apply_cf(input logic init, input logic resteer, input logic br);
        is_init_i    = init;
        is_resteer_i = resteer;
        is_br_i      = br;
        @(negedge clk);
        is_init_i    = 1'b0;
        is_resteer_i = 1'b0;
        is_br_i      = 1'b0;
    endtask

    task automatic wait_pairs(input int n, input logic with_stall);
        int          target;
        int          cycles;
        int          left;
        logic [31:0] r;
        cycles = 0;
        @(posedge clk);
        target = captures + n;
        while (captures < target && cycles < n * PAIR_LIMIT) begin
            @(negedge clk);
            r       = next_rand(stim_state);
            stall_i = with_stall && (r[17:16] == 2'b00);   // about one cycle in four
            @(posedge clk);
            cycles++;
        end
        left = target - captures;
        @(negedge clk);
        stall_i = 1'b0;
        assert (left <= 0) else begin
            $display("pairs not delivered in time: %0d of %0d missing", left, n);
            stim_errors++;
        end
    endtask

    // cold lines miss in both banks right after a new pair
    task automatic wait_miss(input string what);
        int cycles;
        cycles = 0;
        while (!(miss_even_o && miss_odd_o) && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        assert (miss_even_o && miss_odd_o) else begin
            $display("%s: both banks never reported a miss", what);
            stim_errors++;
        end
    endtask

    task automatic end_test(input string name);
        int total;
        @(posedge clk);
        total = cmp_errors + stim_errors;
        test_num++;
        $display("test %0d, %s: %0d failures", test_num, name, total - test_base);
        test_base = total;
        @(negedge clk);
    endtask

    //////////////////////////////////////////////////
    // tests

    initial begin : stimulus
        logic [31:0]     addr;
        fetch_pkg::fip_t even;
        fetch_pkg::fip_t odd;
        int              base;
        int              total;
        stim_state    = SEED;
        rst_n_i       = 1'b0;
        init_addr_i   = '0;
        is_init_i     = 1'b0;
        is_resteer_i  = 1'b0;
        is_br_i       = 1'b0;
        wb_fip_even_i = '0;
        wb_fip_odd_i  = '0;
        bp_fip_even_i = '0;
        bp_fip_odd_i  = '0;
        stall_i       = 1'b0;
        repeat (8) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);

        // cold cache, refill held back
        addr        = 32'h0000_1000;
        init_addr_i = addr;
        apply_cf(1'b1, 1'b0, 1'b0);
        wait_miss("cold cache");
        init_pair(addr, even, odd);
        stim_errors += check_val("miss_addr_even_o", 128'(miss_addr_even_o), 128'(even));
        stim_errors += check_val("miss_addr_odd_o", 128'(miss_addr_odd_o), 128'(odd));
        repeat (6) begin
            @(negedge clk);
            stim_errors += check_val("line_valid_o", 128'(line_valid_o), 128'(1'b0));
        end
        @(posedge clk);
        refill_en = 1'b1;
        @(negedge clk);
        wait_pairs(1, 1'b0);
        end_test("cold cache");

        init_addr_i = 32'h0000_2200;
        apply_cf(1'b1, 1'b0, 1'b0);
        wait_pairs(6, 1'b0);
        end_test("sequential fetch");

        // odd line first, even bank gets the next line
        addr        = 32'h0000_4310;
        init_addr_i = addr;
        apply_cf(1'b1, 1'b0, 1'b0);
        wait_miss("odd-aligned init");
        stim_errors += check_val("miss_addr_odd_o", 128'(miss_addr_odd_o), 128'(addr[31:4]));
        stim_errors += check_val("miss_addr_even_o", 128'(miss_addr_even_o),
                                 128'(fetch_pkg::fip_t'(addr[31:4] + 28'd1)));
        wait_pairs(4, 1'b0);
        end_test("odd-aligned init");

        wb_fip_even_i = 28'h000_0600;
        wb_fip_odd_i  = 28'h000_0601;
        bp_fip_even_i = 28'h000_0800;
        bp_fip_odd_i  = 28'h000_0801;
        init_addr_i   = 32'h0000_a010;
        apply_cf(1'b1, 1'b1, 1'b1);
        wait_pairs(2, 1'b0);
        apply_cf(1'b0, 1'b1, 1'b1);
        wait_pairs(2, 1'b0);
        apply_cf(1'b1, 1'b0, 1'b1);
        wait_pairs(2, 1'b0);
        apply_cf(1'b1, 1'b1, 1'b0);
        wait_pairs(2, 1'b0);
        apply_cf(1'b0, 1'b0, 1'b1);
        wait_pairs(2, 1'b0);
        end_test("control flow priority");

        init_addr_i = next_rand(stim_state) & 32'h000f_fff0;
        apply_cf(1'b1, 1'b0, 1'b0);
        wait_pairs(10, 1'b1);
        end_test("random stall");

        // first pass fills seven pairs, the second pass must hit throughout
        init_addr_i = 32'h0000_e000;
        apply_cf(1'b1, 1'b0, 1'b0);
        wait_pairs(7, 1'b0);
        apply_cf(1'b1, 1'b0, 1'b0);
        @(posedge clk);
        base = miss_count;
        @(negedge clk);
        wait_pairs(6, 1'b0);
        @(posedge clk);
        assert (miss_count == base) else begin
            $display("warm refetch raised a miss in %0d cycles", miss_count - base);
            stim_errors++;
        end
        @(negedge clk);
        end_test("warm hits");

        @(posedge clk);
        total = cmp_errors + stim_errors;
        $display("summary: %0d tests, %0d pairs compared, %0d failures",
                 test_num, captures, total);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not complete",
                 WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

//--- files.f
+incdir+include
logic/fetch_pkg.sv
logic/fetch_lookup_if.sv
logic/fetch_addr_gen.sv
logic/icache_bank.sv
logic/fetch_line_stage.sv
logic/fetch_top.sv
verification/fetch_tb.sv

//--- run.sh
#!/bin/sh
# build the fetch front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f files.f --top-module fetch_tb -o fetch_tb_sim; then
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/fetch_tb_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -qx "No errors" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
